// ==== rtl/lsu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the load/store unit store path
// Widths and depths, the store width encoding and the address word views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsu_pkg;

    // Store queue geometry
    localparam int SQ_DEPTH  = 4;
    localparam int SQ_IDX_W  = $clog2(SQ_DEPTH);

    // Datapath widths
    localparam int TAG_W     = 4;
    localparam int DATA_W    = 32;
    localparam int BYTES     = DATA_W / 8;

    // Byte address splits into a word index and a byte offset
    localparam int ADDR_W    = 6;
    localparam int OFFS_W    = 2;
    localparam int IDX_W     = ADDR_W - OFFS_W;
    localparam int MEM_WORDS = 16;

    // Store width as issued by the decoder
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } lsu_func_t;

    // The queue and the ports see a plain byte address
    // The merge logic and the memory see word index and byte offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [IDX_W-1:0]  idx;
            logic [OFFS_W-1:0] offs;
        } word;
    } lsu_addr_u;

endpackage

// ==== rtl/lsu_store_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Launch bus from the store queue to the commit stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface lsu_store_if;

    // Single cycle strobe, high in the cycle a slot launches
    logic                         en;
    lsu_pkg::lsu_addr_u           addr;
    logic [lsu_pkg::DATA_W-1:0]   data;
    logic [lsu_pkg::TAG_W-1:0]    tag;
    lsu_pkg::lsu_func_t           func;

    // The queue drives a launch
    modport sq   (output en, output addr, output data, output tag, output func);
    // The commit stage captures it
    modport ctrl (input en, input addr, input data, input tag, input func);

endinterface

// ==== rtl/lsu_sq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store queue
// Holds issued stores until the ROB retires them, launches one
// non-speculative store per cycle and frees or relaunches it on update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_sq (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_flush,
    output logic                          o_full,

    // New store from issue
    input  logic                          i_alloc_en,
    input  lsu_pkg::lsu_addr_u            i_alloc_addr,
    input  logic [lsu_pkg::DATA_W-1:0]    i_alloc_data,
    input  logic [lsu_pkg::TAG_W-1:0]     i_alloc_tag,
    input  lsu_pkg::lsu_func_t            i_alloc_func,

    // ROB retirement of a store tag
    input  logic                          i_rob_retire_en,
    input  logic [lsu_pkg::TAG_W-1:0]     i_rob_retire_tag,

    // Pressure and result from the commit stage
    input  logic                          i_stall,
    input  logic                          i_update_en,
    input  logic                          i_update_retry,

    lsu_store_if.sq                       store
);

    // Per-slot payload
    lsu_pkg::lsu_func_t                   slot_func [lsu_pkg::SQ_DEPTH];
    lsu_pkg::lsu_addr_u                   slot_addr [lsu_pkg::SQ_DEPTH];
    logic [lsu_pkg::DATA_W-1:0]           slot_data [lsu_pkg::SQ_DEPTH];
    logic [lsu_pkg::TAG_W-1:0]            slot_tag  [lsu_pkg::SQ_DEPTH];

    // Per-slot state bits
    logic [lsu_pkg::SQ_DEPTH-1:0]         slot_valid;
    logic [lsu_pkg::SQ_DEPTH-1:0]         slot_nonspec;
    logic [lsu_pkg::SQ_DEPTH-1:0]         slot_launched;

    logic [lsu_pkg::SQ_DEPTH-1:0]         empty;
    logic [lsu_pkg::SQ_DEPTH-1:0]         launchable;
    logic [lsu_pkg::SQ_DEPTH-1:0]         alloc_sel;
    logic [lsu_pkg::SQ_DEPTH-1:0]         rob_sel;
    logic [lsu_pkg::SQ_DEPTH-1:0]         launch_sel;
    logic [lsu_pkg::SQ_DEPTH-1:0]         launch_sel_q;
    logic [lsu_pkg::SQ_DEPTH-1:0]         update_sel;
    logic [lsu_pkg::SQ_IDX_W-1:0]         launch_idx;

    assign empty      = ~slot_valid;
    assign launchable = slot_valid & slot_nonspec & ~slot_launched;
    assign o_full     = (empty == '0);

    // Lowest empty slot takes the new store, a flush squashes the allocation
    assign alloc_sel  = {lsu_pkg::SQ_DEPTH{i_alloc_en & ~i_flush}} & (empty & ~(empty - 1'b1));

    // Lowest launchable slot goes out unless a load owns the memory port
    assign launch_sel = {lsu_pkg::SQ_DEPTH{~i_stall}} & (launchable & ~(launchable - 1'b1));

    // The commit stage answers for the slot launched one cycle earlier
    assign update_sel = {lsu_pkg::SQ_DEPTH{i_update_en}} & launch_sel_q;

    always_comb begin
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            // Tags are unique among valid slots so at most one bit is set
            rob_sel[i] = i_rob_retire_en & slot_valid[i] & (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // One-hot launch select to slot number
    always_comb begin
        launch_idx = '0;
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (launch_sel[i]) begin
                launch_idx = i[lsu_pkg::SQ_IDX_W-1:0];
            end
        end
    end

    assign store.en   = |launch_sel;
    assign store.addr = slot_addr[launch_idx];
    assign store.data = slot_data[launch_idx];
    assign store.tag  = slot_tag[launch_idx];
    assign store.func = slot_func[launch_idx];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            slot_valid    <= '0;
            slot_nonspec  <= '0;
            slot_launched <= '0;
            launch_sel_q  <= '0;
        end else begin
            launch_sel_q <= launch_sel;
            for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
                if (alloc_sel[i]) begin
                    slot_valid[i]    <= 1'b1;
                    slot_nonspec[i]  <= 1'b0;
                    slot_launched[i] <= 1'b0;
                end else begin
                    // A commit frees the slot and a retry keeps it even across a flush
                    // Otherwise a flush drops only speculative stores
                    if (update_sel[i]) begin
                        slot_valid[i] <= i_update_retry;
                    end else if (i_flush) begin
                        slot_valid[i] <= slot_valid[i] & slot_nonspec[i];
                    end
                    // Non-speculative stays set until the slot is reused
                    slot_nonspec[i]  <= slot_nonspec[i] | rob_sel[i];
                    // Either update outcome clears launched so a retry can go again
                    slot_launched[i] <= launch_sel[i] | (slot_launched[i] & ~update_sel[i]);
                end
            end
        end
    end

    // Payload is written only on allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                slot_func[i] <= i_alloc_func;
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

endmodule

// ==== rtl/lsu_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory port arbitration and the one-entry commit stage
// Loads win the port, a store in commit either writes or retries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_ctrl (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_ld_en,
    lsu_store_if.ctrl                     store,

    // Back to the store queue
    output logic                          o_sq_stall,
    output logic                          o_update_en,
    output logic                          o_update_retry,

    // Write request towards merge and memory
    output logic                          o_wr_en,
    output lsu_pkg::lsu_addr_u            o_wr_addr,
    output logic [lsu_pkg::DATA_W-1:0]    o_wr_data,
    output lsu_pkg::lsu_func_t            o_wr_func,

    // Commit report
    output logic                          o_st_commit_en,
    output logic [lsu_pkg::TAG_W-1:0]     o_st_commit_tag
);

    // Commit register
    logic                                 cm_en_q;
    lsu_pkg::lsu_addr_u                   cm_addr_q;
    logic [lsu_pkg::DATA_W-1:0]           cm_data_q;
    logic [lsu_pkg::TAG_W-1:0]            cm_tag_q;
    lsu_pkg::lsu_func_t                   cm_func_q;

    // A load this cycle holds the queue back
    assign o_sq_stall = i_ld_en;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            cm_en_q <= 1'b0;
        end else begin
            cm_en_q <= store.en;
        end
    end

    always_ff @(posedge clk) begin
        if (store.en) begin
            cm_addr_q <= store.addr;
            cm_data_q <= store.data;
            cm_tag_q  <= store.tag;
            cm_func_q <= store.func;
        end
    end

    // The queue hears back every commit cycle
    assign o_update_en    = cm_en_q;
    // Load in the commit cycle takes the port and the store retries
    assign o_update_retry = cm_en_q & i_ld_en;

    assign o_wr_en   = cm_en_q & ~i_ld_en;
    assign o_wr_addr = cm_addr_q;
    assign o_wr_data = cm_data_q;
    assign o_wr_func = cm_func_q;

    // Commit is reported in the same cycle the write happens
    assign o_st_commit_en  = o_wr_en;
    assign o_st_commit_tag = cm_tag_q;

endmodule

// ==== rtl/lsu_store_merge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte lane steering for SB, SH and SW stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_store_merge (
    input  logic                          i_wr_en,
    input  lsu_pkg::lsu_addr_u            i_addr,
    input  logic [lsu_pkg::DATA_W-1:0]    i_data,
    input  lsu_pkg::lsu_func_t            i_func,

    output logic                          o_we,
    output logic [lsu_pkg::IDX_W-1:0]     o_word_idx,
    output logic [lsu_pkg::DATA_W-1:0]    o_wdata,
    output logic [lsu_pkg::BYTES-1:0]     o_wmask
);

    // Low byte and low halfword of the store data, zero extended
    logic [lsu_pkg::DATA_W-1:0]           byte_word;
    logic [lsu_pkg::DATA_W-1:0]           half_word;
    logic [lsu_pkg::OFFS_W-1:0]           offs;

    assign byte_word  = {{(lsu_pkg::DATA_W-8){1'b0}}, i_data[7:0]};
    assign half_word  = {{(lsu_pkg::DATA_W-16){1'b0}}, i_data[15:0]};
    assign offs       = i_addr.word.offs;

    assign o_we       = i_wr_en;
    assign o_word_idx = i_addr.word.idx;

    always_comb begin
        case (i_func)
            lsu_pkg::SB: begin
                o_wdata = byte_word << {offs, 3'b000};
                o_wmask = 4'b0001 << offs;
            end
            // Halfwords land on the lane pair picked by offset bit 1
            lsu_pkg::SH: begin
                o_wdata = half_word << {offs[1], 4'b0000};
                o_wmask = 4'b0011 << {offs[1], 1'b0};
            end
            // Word stores take every lane and ignore the offset
            lsu_pkg::SW: begin
                o_wdata = i_data;
                o_wmask = '1;
            end
            default: begin
                o_wdata = i_data;
                o_wmask = '0;
            end
        endcase
    end

endmodule

// ==== rtl/lsu_dmem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port word memory
// Byte-masked writes and registered whole-word loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_dmem (
    input  logic                          clk,
    input  logic                          n_rst,

    // Masked write from the merge logic
    input  logic                          i_we,
    input  logic [lsu_pkg::IDX_W-1:0]     i_word_idx,
    input  logic [lsu_pkg::DATA_W-1:0]    i_wdata,
    input  logic [lsu_pkg::BYTES-1:0]     i_wmask,

    // Load request and result
    input  logic                          i_ld_en,
    input  lsu_pkg::lsu_addr_u            i_ld_addr,
    output logic [lsu_pkg::DATA_W-1:0]    o_ld_data,
    output logic                          o_ld_valid
);

    logic [lsu_pkg::DATA_W-1:0]           mem [lsu_pkg::MEM_WORDS];

    // Reset zeroes every word so loads of untouched addresses are defined
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (i_we) begin
            for (int b = 0; b < lsu_pkg::BYTES; b++) begin
                if (i_wmask[b]) begin
                    mem[i_word_idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ld_valid <= 1'b0;
        end else begin
            o_ld_valid <= i_ld_en;
        end
    end

    // The byte offset is dropped and the whole word comes back
    always_ff @(posedge clk) begin
        if (i_ld_en) begin
            o_ld_data <= mem[i_ld_addr.word.idx];
        end
    end

endmodule

// ==== rtl/lsu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store path top level
// Store queue, commit control, lane merge and data memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_top (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          i_flush,

    input  logic                          i_alloc_en,
    input  logic [lsu_pkg::ADDR_W-1:0]    i_alloc_addr,
    input  logic [lsu_pkg::DATA_W-1:0]    i_alloc_data,
    input  logic [lsu_pkg::TAG_W-1:0]     i_alloc_tag,
    input  lsu_pkg::lsu_func_t            i_alloc_func,

    input  logic                          i_rob_retire_en,
    input  logic [lsu_pkg::TAG_W-1:0]     i_rob_retire_tag,

    input  logic                          i_ld_en,
    input  logic [lsu_pkg::ADDR_W-1:0]    i_ld_addr,

    output logic                          o_full,
    output logic                          o_st_commit_en,
    output logic [lsu_pkg::TAG_W-1:0]     o_st_commit_tag,
    output logic [lsu_pkg::DATA_W-1:0]    o_ld_data,
    output logic                          o_ld_valid
);

    // Byte addresses from the ports enter through the raw view
    lsu_pkg::lsu_addr_u                   alloc_addr;
    lsu_pkg::lsu_addr_u                   ld_addr;

    logic                                 sq_stall;
    logic                                 update_en;
    logic                                 update_retry;

    logic                                 wr_en;
    lsu_pkg::lsu_addr_u                   wr_addr;
    logic [lsu_pkg::DATA_W-1:0]           wr_data;
    lsu_pkg::lsu_func_t                   wr_func;

    // Merge to memory
    logic                                 mem_we;
    logic [lsu_pkg::IDX_W-1:0]            mem_idx;
    logic [lsu_pkg::DATA_W-1:0]           mem_wdata;
    logic [lsu_pkg::BYTES-1:0]            mem_wmask;

    assign alloc_addr.raw = i_alloc_addr;
    assign ld_addr.raw    = i_ld_addr;

    lsu_store_if store_bus ();

    lsu_sq i_lsu_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (o_full),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_addr     (alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_func     (i_alloc_func),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .i_stall          (sq_stall),
        .i_update_en      (update_en),
        .i_update_retry   (update_retry),
        .store            (store_bus.sq)
    );

    lsu_ctrl i_lsu_ctrl (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_ld_en          (i_ld_en),
        .store            (store_bus.ctrl),
        .o_sq_stall       (sq_stall),
        .o_update_en      (update_en),
        .o_update_retry   (update_retry),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_data        (wr_data),
        .o_wr_func        (wr_func),
        .o_st_commit_en   (o_st_commit_en),
        .o_st_commit_tag  (o_st_commit_tag)
    );

    lsu_store_merge i_lsu_store_merge (
        .i_wr_en          (wr_en),
        .i_addr           (wr_addr),
        .i_data           (wr_data),
        .i_func           (wr_func),
        .o_we             (mem_we),
        .o_word_idx       (mem_idx),
        .o_wdata          (mem_wdata),
        .o_wmask          (mem_wmask)
    );

    lsu_dmem i_lsu_dmem (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_we             (mem_we),
        .i_word_idx       (mem_idx),
        .i_wdata          (mem_wdata),
        .i_wmask          (mem_wmask),
        .i_ld_en          (i_ld_en),
        .i_ld_addr        (ld_addr),
        .o_ld_data        (o_ld_data),
        .o_ld_valid       (o_ld_valid)
    );

endmodule

// ==== bench/lsu_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_clkgen (
    output logic o_clk,
    output logic o_n_rst
);

    // Period of 8 time units
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Reset is held low for the first 8 rising edges
    initial begin
        o_n_rst = 1'b0;
        repeat (8) @(posedge o_clk);
        #1;
        o_n_rst = 1'b1;
    end

endmodule

// ==== bench/lsu_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the store queue
// Retire tag match, launch under stall and reset, allocation while full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_sva (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          i_stall,
    input  logic                          i_full,
    input  logic                          i_alloc_en,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]  i_rob_sel,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]  i_launched,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]  i_launch_sel
);

    // Tags are unique among valid slots, so a retire hits one slot at most
    a_rob_onehot: assert property (@(posedge clk) disable iff (!n_rst) $onehot0(i_rob_sel))
        else $error("more than one slot matched the retire tag");

    // A load owns the memory port, so no slot is marked launched after a stalled cycle
    a_no_launch_stall: assert property (@(posedge clk) disable iff (!n_rst)
        i_stall |=> ((i_launched & ~$past(i_launched)) == '0))
        else $error("store launched while stalled");

    // A store offered to a full queue would be lost
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_full |-> !i_alloc_en)
        else $error("store allocated while the queue was full");

    // Every slot is invalid after a reset edge, so the launch strobe stays low
    a_launch_reset: assert property (@(posedge clk) !n_rst |=> (i_launch_sel == '0))
        else $error("launch strobe high out of reset");

endmodule

// ==== bench/lsu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store path testbench with LFSR stimulus and a model memory
// Directed width, full and flush tests, then random loads and traffic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_tb;

    // Stores per test are 3 widths, 4 full, 8 flush, 6 loads and 20 random
    localparam int NUM_STORES = 41;
    localparam int MAX_CYCLES = NUM_STORES * 20 + 200;
    localparam int NUM_TAGS   = 2 ** lsu_pkg::TAG_W;

    logic                         clk;
    logic                         n_rst;
    logic                         i_flush;
    logic                         i_alloc_en;
    logic [5:0]                   i_alloc_addr;
    logic [31:0]                  i_alloc_data;
    logic [3:0]                   i_alloc_tag;
    lsu_pkg::lsu_func_t           i_alloc_func;
    logic                         i_rob_retire_en;
    logic [3:0]                   i_rob_retire_tag;
    logic                         i_ld_en;
    logic [5:0]                   i_ld_addr;
    logic                         o_full;
    logic                         o_st_commit_en;
    logic [3:0]                   o_st_commit_tag;
    logic [31:0]                  o_ld_data;
    logic                         o_ld_valid;

    // Model memory and the table of stores by tag
    logic [31:0]                  model_mem [lsu_pkg::MEM_WORDS];
    logic [5:0]                   st_addr [NUM_TAGS];
    logic [31:0]                  st_data [NUM_TAGS];
    lsu_pkg::lsu_func_t           st_func [NUM_TAGS];
    logic [NUM_TAGS-1:0]          st_live;
    logic [NUM_TAGS-1:0]          st_retired;
    logic [31:0]                  exp_ld_q [$];
    logic [15:0]                  lfsr;
    logic [3:0]                   next_tag;
    logic                         rand_loads;
    int                           outstanding;
    int                           errors;
    int                           cycles;

    lsu_clkgen i_lsu_clkgen (.o_clk(clk), .o_n_rst(n_rst));

    lsu_top i_lsu_top (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_alloc_en(i_alloc_en), .i_alloc_addr(i_alloc_addr), .i_alloc_data(i_alloc_data),
        .i_alloc_tag(i_alloc_tag), .i_alloc_func(i_alloc_func),
        .i_rob_retire_en(i_rob_retire_en), .i_rob_retire_tag(i_rob_retire_tag),
        .i_ld_en(i_ld_en), .i_ld_addr(i_ld_addr), .o_full(o_full),
        .o_st_commit_en(o_st_commit_en), .o_st_commit_tag(o_st_commit_tag),
        .o_ld_data(o_ld_data), .o_ld_valid(o_ld_valid)
    );

    bind lsu_sq lsu_sva i_lsu_sva (
        .clk(clk), .n_rst(n_rst), .i_stall(i_stall), .i_full(o_full),
        .i_alloc_en(i_alloc_en), .i_rob_sel(rob_sel), .i_launched(slot_launched),
        .i_launch_sel(launch_sel)
    );

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected word after a store lands on the old word by the lane rule
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [5:0] addr,
            input logic [31:0] data, input lsu_pkg::lsu_func_t func);
        logic [31:0] word;
        word = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (func == lsu_pkg::SW) begin
                word[8*lane +: 8] = data[8*lane +: 8];
            end else if (func == lsu_pkg::SH && (lane / 2) == addr[1]) begin
                word[8*lane +: 8] = data[8*(lane % 2) +: 8];
            end else if (func == lsu_pkg::SB && lane == addr[1:0]) begin
                word[8*lane +: 8] = data[7:0];
            end
        end
        return word;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
            input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // Ends a cycle, clears the strobes and draws the next random load
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        i_alloc_en      = 1'b0;
        i_rob_retire_en = 1'b0;
        i_flush         = 1'b0;
        i_ld_en         = 1'b0;
        if (rand_loads) begin
            take_bits(2, r);
            if (r[1:0] == 2'b11) begin
                take_bits(6, r);
                i_ld_en   = 1'b1;
                i_ld_addr = r[5:0];
            end
        end
    endtask

    task automatic issue_store(input lsu_pkg::lsu_func_t func, input logic [5:0] addr,
            input logic [31:0] data, output logic [3:0] tag);
        while (st_live[next_tag]) begin
            next_tag++;
        end
        tag = next_tag;
        next_tag++;
        st_live[tag]    = 1'b1;
        st_retired[tag] = 1'b0;
        st_addr[tag]    = addr;
        st_data[tag]    = data;
        st_func[tag]    = func;
        i_alloc_en      = 1'b1;
        i_alloc_addr    = addr;
        i_alloc_data    = data;
        i_alloc_tag     = tag;
        i_alloc_func    = func;
    endtask

    task automatic issue_random(output logic [3:0] tag);
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] f;
        take_bits(6, a);
        take_bits(32, d);
        take_bits(2, f);
        // Code 3 is not a store width and stands for a word store here
        if (f[1:0] == 2'b11) begin
            f = 2;
        end
        issue_store(lsu_pkg::lsu_func_t'(f[1:0]), a[5:0], d, tag);
    endtask

    task automatic retire_tag(input logic [3:0] tag);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        st_retired[tag]  = 1'b1;
        outstanding++;
    endtask

    // Lowest live store that the ROB has not retired yet, or -1
    function automatic int oldest_unretired();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (st_live[t] && !st_retired[t]) begin
                return t;
            end
        end
        return -1;
    endfunction

    task automatic retire_all();
        while (oldest_unretired() >= 0) begin
            retire_tag(oldest_unretired());
            next_cycle();
        end
    endtask

    // Speculative stores are gone after the flush edge
    task automatic flush_spec();
        i_flush = 1'b1;
        st_live = st_live & st_retired;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (outstanding != 0 && n < 100) begin
            next_cycle();
            n++;
        end
        if (outstanding != 0) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (st_live[t] && st_retired[t]) begin
                    report_error($sformatf("store with tag %0d never committed", t));
                    st_live[t] = 1'b0;
                end
            end
            outstanding = 0;
        end
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (o_full && n < 50) begin
            next_cycle();
            n++;
        end
        if (o_full) begin
            report_error("store queue stayed full");
        end
    endtask

    // Load result comes back one cycle after the request
    task automatic load_word(input logic [5:0] addr, output logic [31:0] data);
        i_ld_en   = 1'b1;
        i_ld_addr = addr;
        next_cycle();
        compare_value("o_ld_valid", 1, o_ld_valid);
        data = o_ld_data;
    endtask

    // Compare process checks load results against the model and applies commits to it
    always @(posedge clk) begin
        if (n_rst) begin
            if (o_ld_valid) begin
                if (exp_ld_q.size() == 0) begin
                    report_error("load result with no load pending");
                end else begin
                    compare_value("o_ld_data", exp_ld_q.pop_front(), o_ld_data);
                end
            end
            // A load never shares an edge with a write, so the model is current
            if (i_ld_en) begin
                exp_ld_q.push_back(model_mem[i_ld_addr[5:2]]);
            end
            if (o_st_commit_en) begin
                if (!st_live[o_st_commit_tag] || !st_retired[o_st_commit_tag]) begin
                    report_error($sformatf("commit for tag %0d, not a retired store",
                        o_st_commit_tag));
                end else begin
                    model_mem[st_addr[o_st_commit_tag][5:2]] =
                        merge_store(model_mem[st_addr[o_st_commit_tag][5:2]],
                        st_addr[o_st_commit_tag], st_data[o_st_commit_tag],
                        st_func[o_st_commit_tag]);
                    st_live[o_st_commit_tag] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("ERROR t=%0t run did not finish within %0d cycles", $time, MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [3:0]  tag;
        logic [3:0]  tags [4];
        logic [31:0] r;
        logic [31:0] word;
        int          allocs;
        i_flush          = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc_addr     = '0;
        i_alloc_data     = '0;
        i_alloc_tag      = '0;
        i_alloc_func     = lsu_pkg::SB;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_ld_en          = 1'b0;
        i_ld_addr        = '0;
        lfsr             = 16'd54;
        next_tag         = '0;
        rand_loads       = 1'b0;
        st_live          = '0;
        st_retired       = '0;
        outstanding      = 0;
        errors           = 0;
        cycles           = 0;
        // The DUT clears its memory on reset
        for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        @(posedge n_rst);
        next_cycle();

        // Word, byte and halfword stores into word 1, committed one by one
        issue_store(lsu_pkg::SW, 6'h04, 32'h11223344, tags[0]);
        next_cycle();
        issue_store(lsu_pkg::SB, 6'h05, 32'hCDCDCDAB, tags[1]);
        next_cycle();
        issue_store(lsu_pkg::SH, 6'h06, 32'h1234BEEF, tags[2]);
        next_cycle();
        for (int i = 0; i < 3; i++) begin
            retire_tag(tags[i]);
            next_cycle();
            drain();
        end
        load_word(6'h07, word);
        compare_value("o_ld_data", 32'hBEEFAB44, word);

        // Four unretired stores fill the queue, one commit frees a slot
        for (int i = 0; i < 4; i++) begin
            issue_random(tags[i]);
            next_cycle();
        end
        compare_value("o_full", 1, o_full);
        retire_tag(tags[0]);
        next_cycle();
        drain();
        compare_value("o_full", 0, o_full);
        retire_all();
        drain();

        // Flush keeps the two retired stores only
        for (int i = 0; i < 4; i++) begin
            issue_random(tags[i]);
            next_cycle();
        end
        retire_tag(tags[1]);
        next_cycle();
        retire_tag(tags[3]);
        next_cycle();
        flush_spec();
        next_cycle();
        drain();
        compare_value("o_full", 0, o_full);
        for (int i = 0; i < 4; i++) begin
            issue_random(tag);
            next_cycle();
        end
        compare_value("o_full", 1, o_full);
        retire_all();
        drain();

        // Random loads against retiring stores cause stalls and retries
        rand_loads = 1'b1;
        for (int i = 0; i < 6; i++) begin
            wait_not_full();
            issue_random(tag);
            next_cycle();
            retire_tag(tag);
            next_cycle();
        end
        drain();

        // Mixed random traffic with an occasional flush
        allocs = 0;
        for (int c = 0; c < 400 && allocs < 20; c++) begin
            take_bits(4, r);
            if (r[3:0] == 4'h0) begin
                flush_spec();
            end else begin
                if (r[1] && oldest_unretired() >= 0) begin
                    retire_tag(oldest_unretired());
                end
                if (r[0] && !o_full) begin
                    issue_random(tag);
                    allocs++;
                end
            end
            next_cycle();
        end
        retire_all();
        drain();

        rand_loads = 1'b0;
        repeat (3) next_cycle();
        if (exp_ld_q.size() != 0) begin
            report_error("load issued without a result");
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/lsu_store_if.sv
rtl/lsu_sq.sv
rtl/lsu_ctrl.sv
rtl/lsu_store_merge.sv
rtl/lsu_dmem.sv
rtl/lsu_top.sv
bench/lsu_clkgen.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the store path testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f verilog.f -o lsu_sim
	@out="$$(./obj_dir/lsu_sim)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
